//--- verilog/wb_settings.svh
/*
 * Write-back stage settings
 * Widths and counts shared by the write-back package and RTL
 */

`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Register data width
`define WB_XLEN 32

// Depth of the instruction ID pool, must be a power of two
`define WB_MAX_INFLIGHT 4

// Bits needed to name one ID in the pool
`define WB_ID_W 2

// Execution units reporting into write-back
`define WB_NUM_UNITS 2

// Register number width
`define WB_REG_ADDR_W 5

`endif

//--- verilog/wb_pkg.sv
/*
 * Write-back package
 * Vector typedefs and the packed structs passed between the ID pool,
 * the execution units, the retire logic and the register file
 */

`include "wb_settings.svh"

package wb_pkg;

    ////////////////////////////////////////
    // Plain vectors
    typedef logic [`WB_XLEN-1:0]             data_t;
    typedef logic [`WB_ID_W-1:0]             inst_id_t;
    typedef logic [`WB_MAX_INFLIGHT-1:0]     id_mask_t;
    typedef logic [`WB_REG_ADDR_W-1:0]       reg_addr_t;
    typedef logic [$clog2(`WB_NUM_UNITS)-1:0] unit_sel_t;

    ////////////////////////////////////////
    // Packet table entry, written at issue
    typedef struct packed {
        unit_sel_t unit_sel;
        reg_addr_t rd_addr;
        logic      rd_nzero;
    } inflight_packet_t;

    // Per-unit report, result held until ack
    typedef struct packed {
        logic     done;
        inst_id_t id;
        data_t    result;
    } unit_report_t;

    // One register file write
    typedef struct packed {
        logic      commit;
        reg_addr_t rd_addr;
        logic      rd_nzero;
        data_t     data;
    } rf_commit_t;

endpackage

//--- verilog/id_stack.sv
/*
 * Instruction ID pool
 * Holds every ID in one age-ordered list. In-flight IDs sit at the top,
 * oldest highest, and free IDs below them with the latest freed at 0
 */

`timescale 1ns/1ps

`include "wb_settings.svh"

module id_stack (
    input  logic             clk,
    input  logic             rst,
    input  logic             issued,
    input  logic             retired,
    input  wb_pkg::inst_id_t retired_id,
    output wb_pkg::inst_id_t ordering [`WB_MAX_INFLIGHT-1:0],
    output wb_pkg::inst_id_t next_id,
    output logic             id_available,
    output logic             empty
);
    import wb_pkg::*;

    localparam int DEPTH = `WB_MAX_INFLIGHT;

    inst_id_t          order_r [DEPTH-1:0];
    inst_id_t          order_next [DEPTH-1:0];
    logic [`WB_ID_W:0] inflight_count;
    inst_id_t          free_top;
    id_mask_t          shift_mask;

    ////////////////////////////////////////
    // Issue slot

    // Top free entry, just under the in-flight region
    // DEPTH-1-count reduces to an inversion for a power-of-two depth
    assign free_top = ~inflight_count[`WB_ID_W-1:0];
    assign next_id  = order_r[free_top];

    // Issue moves nothing
    // The count grows over the slot, making it the youngest in flight

    ////////////////////////////////////////
    // Retire shift

    // Mark the retired entry and everything younger than it
    always_comb begin
        logic hit;
        hit = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            hit           = hit | (order_r[i] == retired_id);
            shift_mask[i] = hit;
        end
    end

    // Younger entries move up one place to close the gap
    // Freed ID drops to the bottom of the free region
    always_comb begin
        order_next[0] = retired ? retired_id : order_r[0];
        for (int i = 1; i < DEPTH; i++) begin
            if (retired && shift_mask[i])
                order_next[i] = order_r[i-1];
            else
                order_next[i] = order_r[i];
        end
    end

    ////////////////////////////////////////
    // State
    always_ff @(posedge clk) begin
        if (rst) begin
            // Start with IDs in index order, all free
            for (int i = 0; i < DEPTH; i++)
                order_r[i] <= inst_id_t'(i);
            inflight_count <= '0;
        end else begin
            order_r <= order_next;
            // Issue and retire together leave the count alone
            if (issued && !retired)
                inflight_count <= inflight_count + 1'b1;
            else if (retired && !issued)
                inflight_count <= inflight_count - 1'b1;
        end
    end

    assign ordering = order_r;

    // MSB set only when every ID is in flight
    assign id_available = !inflight_count[`WB_ID_W];
    assign empty        = (inflight_count == '0);

endmodule

//--- verilog/write_back.sv
/*
 * Write-back stage
 * Tracks in-flight instructions, collects unit done pulses, picks one
 * instruction per cycle to retire and commits its result to the
 * register file while acknowledging the owning unit
 */

`timescale 1ns/1ps

`include "wb_settings.svh"

module write_back (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inorder,
    input  logic                     issue,
    input  wb_pkg::inflight_packet_t issue_packet,
    output wb_pkg::inst_id_t         issue_id,
    output logic                     id_available,
    output logic                     queue_empty,
    output wb_pkg::inst_id_t         oldest_id,
    input  wb_pkg::unit_report_t     unit_rep [`WB_NUM_UNITS-1:0],
    output logic [`WB_NUM_UNITS-1:0] unit_ack,
    output wb_pkg::rf_commit_t       rf_wr,
    output logic                     instruction_complete,
    output wb_pkg::inst_id_t         complete_id
);
    import wb_pkg::*;

    localparam int DEPTH = `WB_MAX_INFLIGHT;
    localparam int UNITS = `WB_NUM_UNITS;

    inflight_packet_t packet_table [DEPTH-1:0];
    inflight_packet_t retired_packet;
    inst_id_t         ordering [DEPTH-1:0];

    id_mask_t done_pulse;
    id_mask_t retired_last;
    id_mask_t id_done;
    id_mask_t id_done_r;
    id_mask_t done_ordered;

    logic     retire;
    logic     retire_r;
    inst_id_t retire_id;
    inst_id_t retire_id_r;

    // Age order of IDs, index DEPTH-1 oldest
    id_stack ids0 (
        .clk          (clk),
        .rst          (rst),
        .issued       (issue),
        .retired      (retire),
        .retired_id   (retire_id),
        .ordering     (ordering),
        .next_id      (issue_id),
        .id_available (id_available),
        .empty        (queue_empty)
    );

    assign oldest_id = ordering[DEPTH-1];

    ////////////////////////////////////////
    // Packet table
    // Unit and destination per ID, captured at issue
    always_ff @(posedge clk) begin
        if (issue)
            packet_table[issue_id] <= issue_packet;
    end

    ////////////////////////////////////////
    // Done tracking

    // Unit pulses to one-hot by ID
    always_comb begin
        done_pulse = '0;
        for (int u = 0; u < UNITS; u++) begin
            if (unit_rep[u].done)
                done_pulse[unit_rep[u].id] = 1'b1;
        end
    end

    // Clears the bit of the instruction committed this cycle
    always_comb begin
        retired_last              = '0;
        retired_last[retire_id_r] = retire_r;
    end

    assign id_done = (id_done_r & ~retired_last) | done_pulse;

    always_ff @(posedge clk) begin
        if (rst)
            id_done_r <= '0;
        else
            id_done_r <= id_done;
    end

    ////////////////////////////////////////
    // Retire selection

    // Done bits rearranged by age
    always_comb begin
        for (int i = 0; i < DEPTH; i++)
            done_ordered[i] = id_done[ordering[i]];
    end

    // Highest done position wins, i.e. the oldest finished
    // In-order mode only ever takes the top entry
    always_comb begin
        retire_id = ordering[DEPTH-1];
        for (int i = 0; i < DEPTH; i++) begin
            if (done_ordered[i])
                retire_id = ordering[i];
        end
    end

    assign retire = inorder ? done_ordered[DEPTH-1] : |done_ordered;

    always_ff @(posedge clk) begin
        if (rst)
            retire_r <= 1'b0;
        else
            retire_r <= retire;
    end

    always_ff @(posedge clk) begin
        retire_id_r <= retire_id;
    end

    ////////////////////////////////////////
    // Commit and unit ack
    assign retired_packet = packet_table[retire_id_r];

    always_comb begin
        rf_wr.commit   = retire_r;
        rf_wr.rd_addr  = retired_packet.rd_addr;
        rf_wr.rd_nzero = retired_packet.rd_nzero;
        rf_wr.data     = unit_rep[retired_packet.unit_sel].result;
    end

    // Owning unit may drop its held result after this
    always_comb begin
        for (int u = 0; u < UNITS; u++)
            unit_ack[u] = retire_r && (retired_packet.unit_sel == unit_sel_t'(u));
    end

    assign instruction_complete = retire_r;
    assign complete_id          = retire_id_r;

endmodule

//--- verilog/reg_file.sv
/*
 * Register file
 * One write port fed by write-back commits, one combinational read
 * port, register zero hardwired to zero
 */

`timescale 1ns/1ps

`include "wb_settings.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  wb_pkg::rf_commit_t wr,
    input  wb_pkg::reg_addr_t  rs_addr,
    output wb_pkg::data_t      rs_data
);
    import wb_pkg::*;

    localparam int NUM_REGS = 1 << `WB_REG_ADDR_W;

    data_t regs [NUM_REGS-1:0];

    ////////////////////////////////////////
    // Write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr.commit && wr.rd_nzero) begin
            // Writes to x0 are dropped through rd_nzero
            regs[wr.rd_addr] <= wr.data;
        end
    end

    ////////////////////////////////////////
    // Read port
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

endmodule

//--- verilog/wb_core.sv
/*
 * Write-back core
 * Retire logic joined to the register file, with the register
 * file read port brought out to the top
 */

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inorder,
    input  logic                     issue,
    input  wb_pkg::inflight_packet_t issue_packet,
    output wb_pkg::inst_id_t         issue_id,
    output logic                     id_available,
    output logic                     queue_empty,
    output wb_pkg::inst_id_t         oldest_id,
    input  wb_pkg::unit_report_t     unit_rep [`WB_NUM_UNITS-1:0],
    output logic [`WB_NUM_UNITS-1:0] unit_ack,
    input  wb_pkg::reg_addr_t        rs_addr,
    output wb_pkg::data_t            rs_data,
    output logic                     instruction_complete,
    output wb_pkg::inst_id_t         complete_id
);
    import wb_pkg::*;

    // Commit path into the register file
    rf_commit_t rf_wr;

    write_back wb0 (
        .clk                  (clk),
        .rst                  (rst),
        .inorder              (inorder),
        .issue                (issue),
        .issue_packet         (issue_packet),
        .issue_id             (issue_id),
        .id_available         (id_available),
        .queue_empty          (queue_empty),
        .oldest_id            (oldest_id),
        .unit_rep             (unit_rep),
        .unit_ack             (unit_ack),
        .rf_wr                (rf_wr),
        .instruction_complete (instruction_complete),
        .complete_id          (complete_id)
    );

    reg_file rf0 (
        .clk     (clk),
        .rst     (rst),
        .wr      (rf_wr),
        .rs_addr (rs_addr),
        .rs_data (rs_data)
    );

endmodule

//--- bench/tb_wb_core.sv
/*
 * Write-back core testbench
 * Directed tests with behavioral execution units, a completion
 * monitor and a register reference model kept in completion order
 */

`timescale 1ns/1ps

`include "wb_settings.svh"

module tb_wb_core;
    import wb_pkg::*;

    localparam int DEPTH       = `WB_MAX_INFLIGHT;
    localparam int NUM_REGS    = 1 << `WB_REG_ADDR_W;
    localparam int ACK_TIMEOUT = 40;

    logic                     clk;
    logic                     rst;
    logic                     inorder;
    logic                     issue;
    inflight_packet_t         issue_packet;
    inst_id_t                 issue_id;
    logic                     id_available;
    logic                     queue_empty;
    inst_id_t                 oldest_id;
    unit_report_t             unit_rep [`WB_NUM_UNITS-1:0];
    logic [`WB_NUM_UNITS-1:0] unit_ack;
    reg_addr_t                rs_addr;
    data_t                    rs_data;
    logic                     instruction_complete;
    inst_id_t                 complete_id;

    // Destination and result per ID as noted at issue
    reg_addr_t rd_of [DEPTH];
    data_t     res_of [DEPTH];
    // Completion log and expected register contents
    inst_id_t  comp_q [$];
    data_t     ref_regs [NUM_REGS];

    wb_core dut0 (
        .clk                  (clk),
        .rst                  (rst),
        .inorder              (inorder),
        .issue                (issue),
        .issue_packet         (issue_packet),
        .issue_id             (issue_id),
        .id_available         (id_available),
        .queue_empty          (queue_empty),
        .oldest_id            (oldest_id),
        .unit_rep             (unit_rep),
        .unit_ack             (unit_ack),
        .rs_addr              (rs_addr),
        .rs_data              (rs_data),
        .instruction_complete (instruction_complete),
        .complete_id          (complete_id)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Completion monitor
    // Sampled on the falling edge away from register updates
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                ref_regs[i] = '0;
        end else if (instruction_complete) begin
            comp_q.push_back(complete_id);
            // Retire order decides the register value
            if (rd_of[complete_id] != '0)
                ref_regs[rd_of[complete_id]] = res_of[complete_id];
        end
    end

    ////////////////////////////////////////
    // Helpers
    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Drive point 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic read_reg(input reg_addr_t addr, output data_t data);
        rs_addr = addr;
        #1;
        data = rs_data;
        next_cycle();
    endtask

    // One-cycle issue strobe with the ID taken while the strobe is high
    task automatic issue_one(input unit_sel_t u, input reg_addr_t rd, input data_t res,
                             output inst_id_t id);
        assert (id_available) else begin
            $display("issue attempted with no free instruction ID");
            stop_run();
        end
        issue        = 1'b1;
        issue_packet = '{unit_sel: u, rd_addr: rd, rd_nzero: (rd != '0)};
        id           = issue_id;
        rd_of[id]    = rd;
        res_of[id]   = res;
        next_cycle();
        issue = 1'b0;
    endtask

    // Unit model pulses done and holds the result until the ack cycle is over
    task automatic execute_on_unit(input int u, input inst_id_t id, input data_t res,
                                   input int dly);
        int wait_cnt;
        repeat (dly) next_cycle();
        unit_rep[u].done   = 1'b1;
        unit_rep[u].id     = id;
        unit_rep[u].result = res;
        next_cycle();
        unit_rep[u].done = 1'b0;
        wait_cnt = 0;
        while (!unit_ack[u]) begin
            assert (wait_cnt < ACK_TIMEOUT) else begin
                $display("unit %0d never received an ack for ID %0d", u, id);
                stop_run();
            end
            next_cycle();
            wait_cnt++;
        end
        next_cycle();
        // Stale data makes a late commit visible in the registers
        unit_rep[u].result = ~res;
    endtask

    // A then B on different units with the order checked against the retire rules
    task automatic run_pair(input logic mode, input unit_sel_t ua,
                            input reg_addr_t rd_a, input reg_addr_t rd_b,
                            input data_t res_a, input data_t res_b,
                            input int dly_a, input int dly_b);
        inst_id_t  id_a;
        inst_id_t  id_b;
        unit_sel_t ub;
        int        base;
        logic      a_first;
        base    = comp_q.size();
        inorder = mode;
        ub      = ~ua;
        issue_one(ua, rd_a, res_a, id_a);
        issue_one(ub, rd_b, res_b, id_b);
        assert (id_a != id_b) else begin
            $display("the same instruction ID was handed out twice while in flight");
            stop_run();
        end
        fork
            execute_on_unit(int'(ua), id_a, res_a, dly_a);
            execute_on_unit(int'(ub), id_b, res_b, dly_b);
        join
        // Same-cycle done goes to the older one
        a_first = mode || (dly_a <= dly_b);
        check_val("completion count", comp_q.size(), base + 2);
        check_val("complete_id", 32'(comp_q[base]), a_first ? 32'(id_a) : 32'(id_b));
        check_val("complete_id", 32'(comp_q[base + 1]), a_first ? 32'(id_b) : 32'(id_a));
        check_val("queue_empty", 32'(queue_empty), 32'd1);
    endtask

    ////////////////////////////////////////
    // Tests
    task automatic check_reset_state();
        check_val("queue_empty", 32'(queue_empty), 32'd1);
        check_val("id_available", 32'(id_available), 32'd1);
        check_val("instruction_complete", 32'(instruction_complete), 32'd0);
        check_val("unit_ack", 32'(unit_ack), 32'd0);
    endtask

    task automatic single_instruction_timing();
        inst_id_t id;
        data_t    val;
        int       base;
        base    = comp_q.size();
        inorder = 1'b1;
        issue_one(1'b0, 5'd7, 32'h1234_5678, id);
        // Cycle t
        unit_rep[0].done   = 1'b1;
        unit_rep[0].id     = id;
        unit_rep[0].result = 32'h1234_5678;
        check_val("instruction_complete", 32'(instruction_complete), 32'd0);
        next_cycle();
        // Cycle t+1
        unit_rep[0].done = 1'b0;
        check_val("instruction_complete", 32'(instruction_complete), 32'd1);
        check_val("complete_id", 32'(complete_id), 32'(id));
        check_val("unit_ack", 32'(unit_ack), 32'd1);
        next_cycle();
        // Cycle t+2
        check_val("instruction_complete", 32'(instruction_complete), 32'd0);
        unit_rep[0].result = '0;
        read_reg(5'd7, val);
        check_val("rs_data", val, 32'h1234_5678);
        // Write to x0 completes but is dropped
        issue_one(1'b1, 5'd0, 32'hffff_0000, id);
        execute_on_unit(1, id, 32'hffff_0000, 1);
        read_reg(5'd0, val);
        check_val("rs_data", val, 32'd0);
        check_val("completion count", comp_q.size(), base + 2);
    endtask

    task automatic inorder_retire();
        data_t val;
        run_pair(1'b1, 1'b0, 5'd3, 5'd4, 32'haaaa_0001, 32'hbbbb_0002, 3, 0);
        read_reg(5'd3, val);
        check_val("rs_data", val, 32'haaaa_0001);
        read_reg(5'd4, val);
        check_val("rs_data", val, 32'hbbbb_0002);
    endtask

    task automatic out_of_order_retire();
        data_t val;
        run_pair(1'b0, 1'b1, 5'd5, 5'd6, 32'hcccc_0003, 32'hdddd_0004, 3, 0);
        read_reg(5'd5, val);
        check_val("rs_data", val, 32'hcccc_0003);
        read_reg(5'd6, val);
        check_val("rs_data", val, 32'hdddd_0004);
    endtask

    task automatic pool_full();
        inst_id_t ids [DEPTH];
        int       base;
        base    = comp_q.size();
        inorder = 1'b0;
        for (int i = 0; i < DEPTH; i++)
            issue_one(unit_sel_t'(i % 2), reg_addr_t'(10 + i),
                      data_t'(32'ha000_0000 + i), ids[i]);
        check_val("id_available", 32'(id_available), 32'd0);
        check_val("oldest_id", 32'(oldest_id), 32'(ids[0]));
        execute_on_unit(0, ids[0], 32'ha000_0000, 0);
        check_val("id_available", 32'(id_available), 32'd1);
        for (int i = 1; i < DEPTH; i++)
            execute_on_unit(i % 2, ids[i], data_t'(32'ha000_0000 + i), 0);
        check_val("queue_empty", 32'(queue_empty), 32'd1);
        for (int i = 0; i < DEPTH; i++)
            check_val("complete_id", 32'(comp_q[base + i]), 32'(ids[i]));
    endtask

    task automatic random_mix();
        data_t val;
        // 20 pairs give 40 instructions
        for (int n = 0; n < 20; n++)
            run_pair(1'($urandom), unit_sel_t'($urandom), reg_addr_t'($urandom),
                     reg_addr_t'($urandom), data_t'($urandom), data_t'($urandom),
                     int'($urandom % 4), int'($urandom % 4));
        for (int r = 0; r < NUM_REGS; r++) begin
            read_reg(reg_addr_t'(r), val);
            check_val("rs_data", val, ref_regs[r]);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        void'($urandom(32'hf78d_a7e7));
        rst          = 1'b1;
        inorder      = 1'b0;
        issue        = 1'b0;
        issue_packet = '0;
        rs_addr      = '0;
        for (int u = 0; u < `WB_NUM_UNITS; u++)
            unit_rep[u] = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_state();
        single_instruction_timing();
        inorder_retire();
        out_of_order_retire();
        pool_full();
        random_mix();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/id_stack.sv
verilog/write_back.sv
verilog/reg_file.sv
verilog/wb_core.sv
bench/tb_wb_core.sv

//--- Makefile
# Verilator simulation of the write-back core

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_wb_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
